//--- list.f
logic/job_regfile_pkg.sv
logic/cxt_write_if.sv
logic/read_req_if.sv
logic/offload_ctrl.sv
logic/context_bank.sv
logic/job_dispatch.sv
logic/job_regfile_top.sv
sim/job_regfile_sva.sv
sim/tb_job_regfile.sv

//--- logic/context_bank.sv
// Context bank holding one context's job parameters and its busy flag
`timescale 1ns/1ps

module context_bank
  import job_regfile_pkg::*;
#(
  parameter int unsigned N_IO_REGS = 4,
  parameter int unsigned CXT_ID    = 0
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  cxt_write_if.bank                         wr_if,
  input  logic                              done_stb_i,
  input  logic [CXT_W-1:0]                  done_cxt_i,
  output logic                              busy_o,
  output logic [N_IO_REGS-1:0][DATA_W-1:0]  params_o
);

  logic                             wr_mine;
  logic                             trig_mine;
  logic                             done_mine;
  logic                             busy_q;
  logic [N_IO_REGS-1:0][DATA_W-1:0] regs_q;

  assign wr_mine   = wr_if.wr_stb & (wr_if.wr_cxt == CXT_W'(CXT_ID));
  assign trig_mine = wr_if.trig_stb & (wr_if.trig_cxt == CXT_W'(CXT_ID));
  assign done_mine = done_stb_i & (done_cxt_i == CXT_W'(CXT_ID));

  // Byte lanes under wr_sel, contents survive a soft clear
  always_ff @(posedge clk_i) begin
    if (wr_mine) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (wr_if.wr_sel[b]) begin
          regs_q[wr_if.wr_idx][8*b +: 8] <= wr_if.wr_data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (clear_i) begin
      busy_q <= 1'b0;
    end else if (trig_mine) begin
      busy_q <= 1'b1;
    end else if (done_mine) begin
      busy_q <= 1'b0;  // Retired by the dispatcher
    end
  end

  assign busy_o   = busy_q;
  assign params_o = regs_q;

endmodule

//--- logic/cxt_write_if.sv
// Context write interface carrying parameter writes and job triggers to the banks
`timescale 1ns/1ps

interface cxt_write_if
  import job_regfile_pkg::*;
();

  logic              wr_stb;   // Parameter word write
  logic [CXT_W-1:0]  wr_cxt;
  logic [IDX_W-1:0]  wr_idx;
  logic [DATA_W-1:0] wr_data;
  logic [SEL_W-1:0]  wr_sel;
  logic              trig_stb; // Claims trig_cxt
  logic [CXT_W-1:0]  trig_cxt;

  modport ctrl (
    output wr_stb, wr_cxt, wr_idx, wr_data, wr_sel,
    output trig_stb, trig_cxt
  );

  modport bank (
    input wr_stb, wr_cxt, wr_idx, wr_data, wr_sel,
    input trig_stb, trig_cxt
  );

endinterface

//--- logic/job_dispatch.sv
// Job dispatcher starting the engine in queue order and serving register reads
`timescale 1ns/1ps

module job_dispatch
  import job_regfile_pkg::*;
#(
  parameter int unsigned N_CONTEXTS = 2,
  parameter int unsigned N_IO_REGS  = 4
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              clear_i,
  input  logic                                              done_i,
  input  logic [N_CONTEXTS-1:0]                             busy_i,
  input  logic [N_CONTEXTS-1:0][N_IO_REGS-1:0][DATA_W-1:0]  all_params_i,
  read_req_if.disp                                          rd_if,
  output logic                                              start_o,
  output logic [N_IO_REGS-1:0][DATA_W-1:0]                  params_o,
  output logic [CXT_W-1:0]                                  running_cxt_o,
  output logic                                              done_stb_o,
  output logic [CXT_W-1:0]                                  done_cxt_o,
  output logic [DATA_W-1:0]                                 wb_dat_o
);

  localparam int unsigned PTR_W = $clog2(N_CONTEXTS);
  localparam int unsigned FIN_W = $clog2(FINISHED_MAX + 1);

  logic                launch;
  logic                done_ok;
  logic                fin_rd;
  logic                eng_run_q;      // Engine owns a job
  logic                start_q;
  logic [PTR_W-1:0]    run_ptr_q;      // Oldest queued context
  logic [JOB_ID_W-1:0] running_job_q;
  logic [FIN_W-1:0]    finished_q;
  logic                done_stb_q;
  logic [CXT_W-1:0]    done_cxt_q;
  status_word_u        status;

  assign launch  = ~eng_run_q & ~start_q & busy_i[run_ptr_q];
  assign done_ok = done_i & eng_run_q;   // Stray done pulses are ignored
  assign fin_rd  = rd_if.rd_stb & (rd_if.rd_kind == RD_FINISHED);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      eng_run_q     <= 1'b0;
      start_q       <= 1'b0;
      run_ptr_q     <= '0;
      running_job_q <= '0;
      done_stb_q    <= 1'b0;
      done_cxt_q    <= '0;
    end else if (clear_i) begin
      eng_run_q     <= 1'b0;
      start_q       <= 1'b0;
      run_ptr_q     <= '0;
      running_job_q <= '0;
      done_stb_q    <= 1'b0;
      done_cxt_q    <= '0;
    end else begin
      start_q    <= launch;
      done_stb_q <= done_ok;
      if (start_q) begin
        eng_run_q <= 1'b1;
      end else if (done_ok) begin
        eng_run_q <= 1'b0;
      end
      if (done_ok) begin
        done_cxt_q    <= CXT_W'(run_ptr_q);
        run_ptr_q     <= (run_ptr_q == PTR_W'(N_CONTEXTS - 1)) ? '0 : run_ptr_q + 1'b1;
        running_job_q <= running_job_q + 1'b1;
      end
    end
  end

  // Clear on read, a done on the same edge still counts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      finished_q <= '0;
    end else if (clear_i) begin
      finished_q <= '0;
    end else if (fin_rd) begin
      finished_q <= done_ok ? FIN_W'(1) : '0;
    end else if (done_ok && (finished_q < FIN_W'(FINISHED_MAX))) begin
      finished_q <= finished_q + 1'b1;
    end
  end

  always_comb begin
    status.word = '0;
    for (int c = 0; c < N_CONTEXTS; c++) begin
      status.cxt[c] = {7'b0, busy_i[c]};
    end
  end

  // Request fields are registered in the front end, so data is valid with ack
  always_comb begin
    case (rd_if.rd_kind)
      RD_ACQUIRE:  wb_dat_o = rd_if.acq_word;
      RD_FINISHED: wb_dat_o = DATA_W'(finished_q);
      RD_STATUS:   wb_dat_o = status.word;
      RD_RUNNING:  wb_dat_o = DATA_W'(running_job_q);
      RD_PARAM: begin
        if (rd_if.rd_idx < N_IO_REGS) begin
          wb_dat_o = all_params_i[rd_if.rd_cxt[PTR_W-1:0]][rd_if.rd_idx];
        end else begin
          wb_dat_o = DEAD_WORD;
        end
      end
      default:     wb_dat_o = DEAD_WORD;
    endcase
  end

  assign start_o       = start_q;
  assign params_o      = all_params_i[run_ptr_q];
  assign running_cxt_o = CXT_W'(run_ptr_q);
  assign done_stb_o    = done_stb_q;
  assign done_cxt_o    = done_cxt_q;

endmodule

//--- logic/job_regfile_pkg.sv
// Job register file package with register map, response codes, widths and shared types

package job_regfile_pkg;

  localparam int unsigned DATA_W       = 32;
  localparam int unsigned SEL_W        = DATA_W / 8;
  localparam int unsigned ADR_W        = 8;   // Word address
  localparam int unsigned JOB_ID_W     = 8;
  localparam int unsigned MAX_CONTEXTS = 4;   // One status byte each
  localparam int unsigned CXT_W        = $clog2(MAX_CONTEXTS);
  localparam int unsigned IDX_W        = 4;   // Parameter index field, bits 3:0

  // Control register offsets
  localparam logic [ADR_W-1:0] REG_TRIGGER     = 8'd0;
  localparam logic [ADR_W-1:0] REG_ACQUIRE     = 8'd1;
  localparam logic [ADR_W-1:0] REG_FINISHED    = 8'd2;
  localparam logic [ADR_W-1:0] REG_STATUS      = 8'd3;
  localparam logic [ADR_W-1:0] REG_RUNNING_JOB = 8'd4;

  // Parameter region, context in bits 5:4 below it
  localparam int unsigned IO_REGION_BIT = 6;

  localparam logic [DATA_W-1:0] RESP_ALL_BUSY = '1;  // -1 seen by software
  localparam logic [DATA_W-1:0] DEAD_WORD     = 32'hDEAD_BEEF;
  localparam int unsigned       FINISHED_MAX  = 2;

  typedef enum logic [2:0] {
    RD_ACQUIRE,
    RD_FINISHED,
    RD_STATUS,
    RD_RUNNING,
    RD_PARAM,
    RD_UNKNOWN
  } read_kind_e;

  // STATUS is built per context and read back as one word
  typedef union packed {
    logic [MAX_CONTEXTS-1:0][7:0] cxt;
    logic [DATA_W-1:0]            word;
  } status_word_u;

endpackage

//--- logic/job_regfile_top.sv
// Job offload register file top level with Wishbone slave and engine ports
`timescale 1ns/1ps

module job_regfile_top
  import job_regfile_pkg::*;
#(
  parameter int unsigned N_CONTEXTS = 2,
  parameter int unsigned N_IO_REGS  = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             clear_i,
  input  logic                             wb_cyc_i,
  input  logic                             wb_stb_i,
  input  logic                             wb_we_i,
  input  logic [ADR_W-1:0]                 wb_adr_i,
  input  logic [DATA_W-1:0]                wb_dat_i,
  input  logic [SEL_W-1:0]                 wb_sel_i,
  output logic [DATA_W-1:0]                wb_dat_o,
  output logic                             wb_ack_o,
  output logic                             start_o,
  output logic [N_IO_REGS-1:0][DATA_W-1:0] params_o,
  output logic [CXT_W-1:0]                 running_cxt_o,
  input  logic                             done_i
);

  logic [N_CONTEXTS-1:0]                            busy;
  logic [N_CONTEXTS-1:0][N_IO_REGS-1:0][DATA_W-1:0] all_params;
  logic                                             done_stb;
  logic [CXT_W-1:0]                                 done_cxt;

  cxt_write_if cw_if ();
  read_req_if  rr_if ();

  offload_ctrl #(
    .N_CONTEXTS (N_CONTEXTS),
    .N_IO_REGS  (N_IO_REGS)
  ) u_ctrl (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (clear_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .busy_i   (busy),
    .wb_ack_o (wb_ack_o),
    .wr_if    (cw_if),
    .rd_if    (rr_if)
  );

  for (genvar c = 0; c < N_CONTEXTS; c++) begin : g_bank
    context_bank #(
      .N_IO_REGS (N_IO_REGS),
      .CXT_ID    (c)
    ) u_bank (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .clear_i    (clear_i),
      .wr_if      (cw_if),
      .done_stb_i (done_stb),
      .done_cxt_i (done_cxt),
      .busy_o     (busy[c]),
      .params_o   (all_params[c])
    );
  end

  job_dispatch #(
    .N_CONTEXTS (N_CONTEXTS),
    .N_IO_REGS  (N_IO_REGS)
  ) u_disp (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .done_i        (done_i),
    .busy_i        (busy),
    .all_params_i  (all_params),
    .rd_if         (rr_if),
    .start_o       (start_o),
    .params_o      (params_o),
    .running_cxt_o (running_cxt_o),
    .done_stb_o    (done_stb),
    .done_cxt_o    (done_cxt),
    .wb_dat_o      (wb_dat_o)
  );

endmodule

//--- logic/offload_ctrl.sv
// Offload controller decoding Wishbone accesses and keeping the offload queue pointer
`timescale 1ns/1ps

module offload_ctrl
  import job_regfile_pkg::*;
#(
  parameter int unsigned N_CONTEXTS = 2,
  parameter int unsigned N_IO_REGS  = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [ADR_W-1:0]      wb_adr_i,
  input  logic [DATA_W-1:0]     wb_dat_i,
  input  logic [SEL_W-1:0]      wb_sel_i,
  input  logic [N_CONTEXTS-1:0] busy_i,
  output logic                  wb_ack_o,
  cxt_write_if.ctrl             wr_if,
  read_req_if.ctrl              rd_if
);

  localparam int unsigned PTR_W = $clog2(N_CONTEXTS);

  logic              req;
  logic [CXT_W-1:0]  adr_cxt;
  logic [IDX_W-1:0]  adr_idx;
  logic              io_hit;
  logic              wr_hit;
  logic              trig_hit;
  read_kind_e        kind;

  logic              ack_q;
  logic              wr_stb_q;
  logic              trig_stb_q;
  logic              rd_stb_q;
  logic [PTR_W-1:0]  off_ptr_q;   // Next context to be claimed
  logic [JOB_ID_W-1:0] job_id_q;

  logic [CXT_W-1:0]  cxt_q;
  logic [IDX_W-1:0]  idx_q;
  logic [DATA_W-1:0] data_q;
  logic [SEL_W-1:0]  sel_q;
  logic [CXT_W-1:0]  trig_cxt_q;
  read_kind_e        kind_q;
  logic [DATA_W-1:0] acq_word_q;

  // New request only while no ack is pending
  assign req     = wb_cyc_i & wb_stb_i & ~ack_q;
  assign adr_cxt = wb_adr_i[IO_REGION_BIT-1 -: CXT_W];
  assign adr_idx = wb_adr_i[IDX_W-1:0];
  assign io_hit  = wb_adr_i[IO_REGION_BIT] && (adr_cxt < N_CONTEXTS);

  assign wr_hit   = req & wb_we_i & io_hit & (adr_idx < N_IO_REGS);
  assign trig_hit = req & wb_we_i & (wb_adr_i == REG_TRIGGER) & ~busy_i[off_ptr_q];

  always_comb begin
    if (io_hit) begin
      kind = RD_PARAM;
    end else begin
      case (wb_adr_i)
        REG_ACQUIRE:     kind = RD_ACQUIRE;
        REG_FINISHED:    kind = RD_FINISHED;
        REG_STATUS:      kind = RD_STATUS;
        REG_RUNNING_JOB: kind = RD_RUNNING;
        default:         kind = RD_UNKNOWN;  // Trigger reads land here too
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      wr_stb_q   <= 1'b0;
      trig_stb_q <= 1'b0;
      rd_stb_q   <= 1'b0;
      off_ptr_q  <= '0;
      job_id_q   <= '0;
    end else if (clear_i) begin
      ack_q      <= 1'b0;
      wr_stb_q   <= 1'b0;
      trig_stb_q <= 1'b0;
      rd_stb_q   <= 1'b0;
      off_ptr_q  <= '0;
      job_id_q   <= '0;
    end else begin
      ack_q      <= req;
      wr_stb_q   <= wr_hit;
      trig_stb_q <= trig_hit;
      rd_stb_q   <= req & ~wb_we_i;
      if (trig_hit) begin
        off_ptr_q <= (off_ptr_q == PTR_W'(N_CONTEXTS - 1)) ? '0 : off_ptr_q + 1'b1;
        job_id_q  <= job_id_q + 1'b1;
      end
    end
  end

  // Request fields, only qualified by the strobes above
  always_ff @(posedge clk_i) begin
    if (req) begin
      cxt_q      <= adr_cxt;
      idx_q      <= adr_idx;
      data_q     <= wb_dat_i;
      sel_q      <= wb_sel_i;
      kind_q     <= kind;
      trig_cxt_q <= CXT_W'(off_ptr_q);
      // Acquire only peeks, trigger does the claim
      acq_word_q <= busy_i[off_ptr_q] ? RESP_ALL_BUSY : DATA_W'(job_id_q);
    end
  end

  assign wb_ack_o = ack_q;

  assign wr_if.wr_stb   = wr_stb_q;
  assign wr_if.wr_cxt   = cxt_q;
  assign wr_if.wr_idx   = idx_q;
  assign wr_if.wr_data  = data_q;
  assign wr_if.wr_sel   = sel_q;
  assign wr_if.trig_stb = trig_stb_q;
  assign wr_if.trig_cxt = trig_cxt_q;

  assign rd_if.rd_stb   = rd_stb_q;
  assign rd_if.rd_kind  = kind_q;
  assign rd_if.rd_cxt   = cxt_q;
  assign rd_if.rd_idx   = idx_q;
  assign rd_if.acq_word = acq_word_q;

endmodule

//--- logic/read_req_if.sv
// Read request interface from the offload controller to the dispatcher
`timescale 1ns/1ps

interface read_req_if
  import job_regfile_pkg::*;
();

  logic              rd_stb;    // High during the ack of a read
  read_kind_e        rd_kind;
  logic [CXT_W-1:0]  rd_cxt;
  logic [IDX_W-1:0]  rd_idx;
  logic [DATA_W-1:0] acq_word;  // Acquire response, settled at request time

  modport ctrl (
    output rd_stb, rd_kind, rd_cxt, rd_idx, acq_word
  );

  modport disp (
    input rd_stb, rd_kind, rd_cxt, rd_idx, acq_word
  );

endinterface

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the job register file testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_job_regfile \
    -Mdir obj_dir -f list.f > build.log 2>&1; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_job_regfile +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
echo "Simulation finished without failure"
exit 0

//--- sim/job_regfile_sva.sv
// Job register file checker for Wishbone handshake and engine dispatch timing
`timescale 1ns/1ps

module job_regfile_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic start_o,
  input logic done_i
);

  int unsigned fail_cnt = 0;
  logic        run_q;    // Engine holds a job

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q <= 1'b0;
    end else if (clear_i) begin
      run_q <= 1'b0;
    end else if (start_o) begin
      run_q <= 1'b1;
    end else if (done_i) begin
      run_q <= 1'b0;
    end
  end

  ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wb_cyc_i && wb_stb_i && !wb_ack_o && !clear_i) |=> wb_ack_o)
    else begin
      fail_cnt++;
      $error("wb_ack_o did not follow a request");
    end

  ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |=> !wb_ack_o)
    else begin
      fail_cnt++;
      $error("wb_ack_o high for more than one cycle");
    end

  no_start_while_running: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_o |-> !run_q)
    else begin
      fail_cnt++;
      $error("start_o while a job is running");
    end

endmodule

bind job_regfile_top job_regfile_sva u_sva (
  .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear_i), .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i), .wb_ack_o (wb_ack_o), .start_o (start_o), .done_i (done_i)
);

//--- sim/tb_job_regfile.sv
// Job register file testbench driving Wishbone accesses and modeling the accelerator engine
`timescale 1ns/1ps

module tb_job_regfile
  import job_regfile_pkg::*;
();

  localparam int unsigned N_CONTEXTS = 4;
  localparam int unsigned N_IO_REGS  = 4;
  localparam int          TIMEOUT    = 200;  // Cycles per wait loop

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic                             clear;
  logic                             wb_cyc;
  logic                             wb_stb;
  logic                             wb_we;
  logic [ADR_W-1:0]                 wb_adr;
  logic [DATA_W-1:0]                wb_wdat;
  logic [SEL_W-1:0]                 wb_sel;
  logic [DATA_W-1:0]                wb_rdat;
  logic                             wb_ack;
  logic                             start;
  logic [N_IO_REGS-1:0][DATA_W-1:0] params;
  logic [CXT_W-1:0]                 running_cxt;
  logic                             done = 1'b0;

  logic [DATA_W-1:0] exp_par [N_CONTEXTS][N_IO_REGS];  // Written parameter words
  int seed    = 28004;
  int checks  = 0;
  int errors  = 0;
  int started = 0;
  int retired = 0;
  bit eng_en  = 1'b0;   // Engine model answers starts only when set
  bit timed_out = 1'b0; // Set by a wait loop that gave up

  always #10 clk = ~clk;

  job_regfile_top #(
    .N_CONTEXTS (N_CONTEXTS),
    .N_IO_REGS  (N_IO_REGS)
  ) i_dut (
    .clk_i (clk), .rst_ni (rst_n), .clear_i (clear),
    .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat), .wb_sel_i (wb_sel), .wb_dat_o (wb_rdat), .wb_ack_o (wb_ack),
    .start_o (start), .params_o (params), .running_cxt_o (running_cxt), .done_i (done)
  );

  task automatic flag_timeout(input string what);
    $display("Timeout while %s at %0t", what, $time);
    timed_out = 1'b1;
  endtask

  // Ends the run once any wait loop has given up
  initial begin : timeout_guard
    @(posedge timed_out);
    $display("*** FAILED ***");
    $finish;
  end

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // One classic cycle, read data is taken while ack is high
  task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                           input logic [DATA_W-1:0] wdat, input logic [SEL_W-1:0] sel,
                           output logic [DATA_W-1:0] rdat);
    int n;
    @(posedge clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= we;
    wb_adr  <= adr;
    wb_wdat <= wdat;
    wb_sel  <= sel;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!wb_ack && n < TIMEOUT);
    if (!wb_ack) flag_timeout("waiting for wb_ack_o");
    rdat = wb_rdat;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                           input logic [SEL_W-1:0] sel);
    logic [DATA_W-1:0] unused;
    bus_cycle(1'b1, adr, dat, sel, unused);
  endtask

  task automatic read_expect(input string name, input logic [ADR_W-1:0] adr,
                             input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] got;
    bus_cycle(1'b0, adr, '0, '0, got);
    check_value(name, got, exp);
  endtask

  task automatic wait_retired(input int target);
    int n;
    n = 0;
    while (retired < target && n < 20 * TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (retired < target) flag_timeout("waiting for job completion");
  endtask

  task automatic report_test(input int num, input string name, input int mark);
    $display("Test %0d %s finished with %0d errors", num, name, errors - mark);
  endtask

  function automatic logic [ADR_W-1:0] param_adr(input int cxt, input int idx);
    return ADR_W'((1 << IO_REGION_BIT) + (cxt << 4) + idx);
  endfunction

  function automatic logic [DATA_W-1:0] busy_word(input int last);  // Bytes 0..last set
    logic [DATA_W-1:0] w;
    w = '0;
    for (int j = 0; j <= last; j++) begin
      w[8*j] = 1'b1;
    end
    return w;
  endfunction

  // Each start must take the next context in queue order
  always @(negedge clk) begin : start_monitor
    int c;
    if (start) begin
      c = started % N_CONTEXTS;
      check_value("running_cxt_o", DATA_W'(running_cxt), DATA_W'(c));
      for (int i = 0; i < N_IO_REGS; i++) begin
        check_value("params_o", params[i], exp_par[c][i]);
      end
      started++;
    end
  end

  initial begin : engine_model
    int d;
    forever begin
      @(negedge clk);
      if (eng_en && started > retired) begin
        d = 3 + ({$random(seed)} % 8);
        repeat (d) @(posedge clk);
        done <= 1'b1;
        @(posedge clk);
        done <= 1'b0;
        retired++;
      end
    end
  end

  initial begin : main
    logic [DATA_W-1:0] w;
    logic [SEL_W-1:0]  sel;
    int                mark;
    rst_n = 1'b0;
    clear = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_wdat = '0;
    wb_sel = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    mark = errors;  // Full write, then a random partial write merged on top
    for (int c = 0; c < N_CONTEXTS; c++) begin
      for (int i = 0; i < N_IO_REGS; i++) begin
        w = $random(seed);
        write_reg(param_adr(c, i), w, '1);
        exp_par[c][i] = w;
        w = $random(seed);
        sel = SEL_W'($random(seed));
        write_reg(param_adr(c, i), w, sel);
        for (int b = 0; b < SEL_W; b++) begin
          if (sel[b]) exp_par[c][i][8*b +: 8] = w[8*b +: 8];
        end
      end
    end
    for (int c = 0; c < N_CONTEXTS; c++) begin
      for (int i = 0; i < N_IO_REGS; i++) begin
        read_expect("param word", param_adr(c, i), exp_par[c][i]);
      end
    end
    read_expect("param beyond N_IO_REGS", param_adr(1, N_IO_REGS), DEAD_WORD);
    report_test(1, "parameter read back", mark);

    mark = errors;
    for (int k = 0; k < N_CONTEXTS; k++) begin
      read_expect("acquire", REG_ACQUIRE, DATA_W'(k));
      write_reg(REG_TRIGGER, '0, '1);
      read_expect("status", REG_STATUS, busy_word(k));
    end
    read_expect("acquire when full", REG_ACQUIRE, RESP_ALL_BUSY);
    report_test(2, "acquire trigger status", mark);

    mark = errors;
    eng_en = 1'b1;
    wait_retired(N_CONTEXTS);
    check_value("start count", DATA_W'(started), DATA_W'(N_CONTEXTS));
    read_expect("status after dispatch", REG_STATUS, '0);
    report_test(3, "dispatch order", mark);

    mark = errors;
    read_expect("running job", REG_RUNNING_JOB, DATA_W'(retired % 256));
    read_expect("finished saturated", REG_FINISHED, DATA_W'(FINISHED_MAX));
    read_expect("finished after read", REG_FINISHED, '0);
    repeat (3) write_reg(REG_TRIGGER, '0, '1);
    wait_retired(N_CONTEXTS + 3);
    read_expect("running job", REG_RUNNING_JOB, DATA_W'(retired % 256));
    read_expect("finished after three jobs", REG_FINISHED, DATA_W'(FINISHED_MAX));
    read_expect("finished after read", REG_FINISHED, '0);
    report_test(4, "counters", mark);

    mark = errors;
    write_reg(REG_TRIGGER, '0, '1);
    wait_retired(N_CONTEXTS + 4);
    eng_en = 1'b0;
    write_reg(REG_TRIGGER, '0, '1);  // Left running when the clear hits
    repeat (3) @(posedge clk);
    clear <= 1'b1;
    @(posedge clk);
    clear <= 1'b0;
    read_expect("status after clear", REG_STATUS, '0);
    read_expect("finished after clear", REG_FINISHED, '0);
    read_expect("running job after clear", REG_RUNNING_JOB, '0);
    read_expect("acquire after clear", REG_ACQUIRE, '0);
    report_test(5, "soft clear", mark);

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, i_dut.u_sva.fail_cnt);
    if (errors == 0 && i_dut.u_sva.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
